// File: dv/pq_stim.txt
# columns: test command a b
# I rank meta = insert, R rank meta = remove and expect, N count = entries, F flag = full
reset N 0
reset F 0
few I 300 31
few I 120 12
few I 450 45
few N 3
few R 120 12
few R 300 31
few R 450 45
few N 0
spill I 900 90
spill I 800 80
spill I 700 70
spill I 600 60
spill I 500 50
spill I 400 40
spill I 350 35
spill I 250 25
spill I 200 20
spill I 150 15
spill N 10
spill R 150 15
spill R 200 20
spill R 250 25
spill R 350 35
spill R 400 40
spill R 500 50
spill R 600 60
spill R 700 70
spill R 800 80
spill R 900 90
spill N 0
mixed I 520 1
mixed I 80 2
mixed I 610 3
mixed R 80 2
mixed I 33 4
mixed I 700 5
mixed I 410 6
mixed I 95 7
mixed N 6
mixed R 33 4
mixed R 95 7
mixed I 60 8
mixed I 880 9
mixed I 15 10
mixed N 7
mixed R 15 10
mixed R 60 8
mixed R 410 6
mixed I 444 11
mixed R 444 11
mixed R 520 1
mixed R 610 3
mixed R 700 5
mixed N 1
mixed R 880 9
mixed N 0
full I 10 100
full I 335 101
full I 660 102
full I 135 103
full I 460 104
full I 785 105
full I 260 106
full I 585 107
full I 60 108
full I 385 109
full I 710 110
full I 185 111
full I 510 112
full I 835 113
full I 310 114
full I 635 115
full I 110 116
full I 435 117
full I 760 118
full I 235 119
full I 560 120
full I 35 121
full I 360 122
full I 685 123
full I 160 124
full I 485 125
full I 810 126
full I 285 127
full I 610 128
full I 85 129
full I 410 130
full I 735 131
full I 210 132
full I 535 133
full F 1
full N 34
full R 10 100
full F 0
full N 33

// File: compile.f
rtl/pq_entry_pkg.sv
rtl/pq_list_pkg.sv
rtl/rank_cache.sv
rtl/free_list.sv
rtl/node_store.sv
rtl/list_engine.sv
rtl/spill_ctrl.sv
rtl/pq_top.sv
dv/pq_tb.sv

// File: Bender.yml
package:
  name: pq

sources:
  - files:
      - rtl/pq_entry_pkg.sv
      - rtl/pq_list_pkg.sv
      - rtl/rank_cache.sv
      - rtl/free_list.sv
      - rtl/node_store.sv
      - rtl/list_engine.sv
      - rtl/spill_ctrl.sv
      - rtl/pq_top.sv
  - target: test
    files:
      - dv/pq_tb.sv

// File: dv/pq_tb.sv
`default_nettype none

module pq_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CACHE_DEPTH = 4;
	localparam int NUM_W = $clog2(CACHE_DEPTH + pq_list_pkg::LIST_CAPACITY + 1);
	localparam int INIT_CYCLES = 100;
	localparam int LINE_CYCLES = 3 * pq_list_pkg::NODE_COUNT + 10;
	localparam string STIM_FILE = "dv/pq_stim.txt";

	logic clk;
	logic rst;
	logic insert;
	logic remove;
	pq_entry_pkg::rank_t rank_in;
	pq_entry_pkg::meta_t meta_in;
	pq_entry_pkg::rank_t rank_out;
	pq_entry_pkg::meta_t meta_out;
	logic valid_out;
	logic busy;
	logic full;
	logic [NUM_W-1:0] num_entries;

	// Parsed stimulus with one entry per command line
	string test_names [$];
	string commands [$];
	int arg_a [$];
	int arg_b [$];

	string cur_test;
	int test_checks;
	int test_errors;
	int tests_run;
	int tests_failed;
	int total_checks;
	int total_errors;
	int budget_cycles = 0;

	pq_top #(
		.CACHE_DEPTH(CACHE_DEPTH)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.insert(insert),
		.remove(remove),
		.rank_in(rank_in),
		.meta_in(meta_in),
		.rank_out(rank_out),
		.meta_out(meta_out),
		.valid_out(valid_out),
		.busy(busy),
		.full(full),
		.num_entries(num_entries)
	);

	always #4ns clk = ~clk;

	task automatic note_failure(input string msg);
		$display("%s: %s", cur_test, msg);
		test_errors++;
	endtask

	task automatic check_rank(input pq_entry_pkg::rank_t expected,
		input pq_entry_pkg::rank_t actual);
		test_checks++;
		if (actual !== expected)
		begin
			$display("error %s: rank_out expected %0d actual %0d", cur_test, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_meta(input pq_entry_pkg::meta_t expected,
		input pq_entry_pkg::meta_t actual);
		test_checks++;
		if (actual !== expected)
		begin
			$display("error %s: meta_out expected %0d actual %0d", cur_test, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_count(input logic [NUM_W-1:0] expected,
		input logic [NUM_W-1:0] actual);
		test_checks++;
		if (actual !== expected)
		begin
			$display("error %s: num_entries expected %0d actual %0d", cur_test, expected,
				actual);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string signal, input logic expected, input logic actual);
		test_checks++;
		if (actual !== expected)
		begin
			$display("error %s: %s expected %0b actual %0b", cur_test, signal, expected,
				actual);
			test_errors++;
		end
	endtask

	// Sampled on falling edges, where every DUT output is settled
	task automatic wait_ready(input int limit, output bit ok);
		int waited;
		waited = 0;
		while (busy !== 1'b0 && waited < limit)
		begin
			@(negedge clk);
			waited++;
		end
		ok = (busy === 1'b0);
		if (!ok)
			note_failure($sformatf("busy stayed high for %0d cycles", limit));
	endtask

	task automatic push_entry(input pq_entry_pkg::rank_t rank, input pq_entry_pkg::meta_t meta);
		bit ok;
		wait_ready(LINE_CYCLES, ok);
		if (ok && full === 1'b1)
			note_failure("insert not possible because the queue reports full");
		else if (ok)
		begin
			insert = 1'b1;
			rank_in = rank;
			meta_in = meta;
			@(negedge clk);
			insert = 1'b0;
		end
	endtask

	// valid_out follows the accepting edge by exactly one cycle
	task automatic pop_and_check(input pq_entry_pkg::rank_t rank,
		input pq_entry_pkg::meta_t meta);
		bit ok;
		wait_ready(LINE_CYCLES, ok);
		if (ok)
		begin
			remove = 1'b1;
			@(negedge clk);
			remove = 1'b0;
			if (valid_out !== 1'b1)
				note_failure("valid_out did not rise one cycle after the remove");
			else
			begin
				check_rank(rank, rank_out);
				check_meta(meta, meta_out);
			end
			// A single remove gives a pulse of one cycle
			@(negedge clk);
			check_flag("valid_out", 1'b0, valid_out);
		end
	endtask

	task automatic run_command(input string cmd, input int a, input int b);
		bit ok;
		if (cmd == "I")
			push_entry(pq_entry_pkg::rank_t'(a), pq_entry_pkg::meta_t'(b));
		else if (cmd == "R")
			pop_and_check(pq_entry_pkg::rank_t'(a), pq_entry_pkg::meta_t'(b));
		else if (cmd == "N")
		begin
			wait_ready(LINE_CYCLES, ok);
			if (ok)
				check_count(NUM_W'(a), num_entries);
		end
		else if (cmd == "F")
		begin
			wait_ready(LINE_CYCLES, ok);
			if (ok)
				check_flag("full", a[0], full);
		end
		else
			note_failure($sformatf("unknown command %s in the stimulus file", cmd));
	endtask

	task automatic close_test();
		if (cur_test.len() > 0)
		begin
			tests_run++;
			if (test_errors == 0)
				$display("test %s: ok, %0d checks", cur_test, test_checks);
			else
			begin
				tests_failed++;
				$display("test %s: FAILED, %0d errors in %0d checks", cur_test, test_errors,
					test_checks);
			end
			total_checks += test_checks;
			total_errors += test_errors;
		end
		test_checks = 0;
		test_errors = 0;
	endtask

	// Lines starting with # are comments and blank lines are skipped
	task automatic load_stimulus(output bit ok);
		int fd;
		int n;
		int a;
		int b;
		string line;
		string name;
		string cmd;
		fd = $fopen(STIM_FILE, "r");
		ok = (fd != 0);
		if (ok)
		begin
			while (!$feof(fd))
			begin
				line = "";
				a = 0;
				b = 0;
				void'($fgets(line, fd));
				n = $sscanf(line, "%s %s %d %d", name, cmd, a, b);
				if (line.len() > 0 && line.getc(0) != "#" && n > 0)
				begin
					if (n < 3)
					begin
						$display("malformed stimulus line: %s", line);
						total_errors++;
					end
					else
					begin
						test_names.push_back(name);
						commands.push_back(cmd);
						arg_a.push_back(a);
						arg_b.push_back(b);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	initial
	begin
		bit loaded;
		bit ok;
		clk = 1'b0;
		rst = 1'b1;
		insert = 1'b0;
		remove = 1'b0;
		rank_in = '0;
		meta_in = '0;
		cur_test = "";
		test_checks = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		total_checks = 0;
		total_errors = 0;

		load_stimulus(loaded);
		if (!loaded)
		begin
			$display("could not open the stimulus file %s", STIM_FILE);
			total_errors++;
		end
		else if (commands.size() == 0)
		begin
			$display("the stimulus file %s holds no commands", STIM_FILE);
			total_errors++;
		end
		budget_cycles = commands.size() * LINE_CYCLES + INIT_CYCLES;

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Outputs right after reset and the end of the init sequence
		cur_test = "reset";
		check_flag("valid_out", 1'b0, valid_out);
		wait_ready(INIT_CYCLES, ok);

		for (int i = 0; i < commands.size(); i++)
		begin
			if (test_names[i] != cur_test)
			begin
				close_test();
				cur_test = test_names[i];
			end
			run_command(commands[i], arg_a[i], arg_b[i]);
		end
		close_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
			total_checks, total_errors);
		if (total_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Budget covers the longest list walk for every command plus init
	initial
	begin
		wait (budget_cycles > 0);
		repeat (budget_cycles) @(posedge clk);
		$display("watchdog: run timed out after %0d cycles", budget_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/pq_top.sv
`default_nettype none

module pq_top #(
	parameter int CACHE_DEPTH = 4,
	localparam int NUM_W = $clog2(CACHE_DEPTH + pq_list_pkg::LIST_CAPACITY + 1)
) (
	input wire clk,
	input wire rst,
	input wire insert,
	input wire remove,
	input wire pq_entry_pkg::rank_t rank_in,
	input wire pq_entry_pkg::meta_t meta_in,
	output pq_entry_pkg::rank_t rank_out,
	output pq_entry_pkg::meta_t meta_out,
	output logic valid_out,
	output logic busy,
	output logic full,
	output logic [NUM_W-1:0] num_entries
);

	// Cache command and status
	logic cache_insert;
	logic cache_evict;
	logic cache_remove;
	logic cache_empty;
	logic cache_full;
	pq_entry_pkg::rank_t cache_rank;
	pq_entry_pkg::rank_t cache_max_rank;
	pq_entry_pkg::meta_t cache_meta;
	pq_entry_pkg::meta_t cache_max_meta;
	logic [$clog2(CACHE_DEPTH + 1)-1:0] cache_count;

	// List engine handshake
	logic ins_req;
	logic pop_req;
	logic pop_valid;
	logic engine_idle;
	pq_entry_pkg::rank_t ins_rank;
	pq_entry_pkg::rank_t pop_rank;
	pq_entry_pkg::meta_t ins_meta;
	pq_entry_pkg::meta_t pop_meta;
	pq_list_pkg::list_count_t list_count;

	// Node memory ports
	logic rank_wr;
	logic meta_wr;
	logic rptr_wr;
	logic lptr_wr;
	pq_entry_pkg::rank_t rank_wdata;
	pq_entry_pkg::rank_t rank_rdata;
	pq_entry_pkg::meta_t meta_wdata;
	pq_entry_pkg::meta_t meta_rdata;
	pq_list_pkg::node_ptr_t rank_waddr;
	pq_list_pkg::node_ptr_t rank_raddr;
	pq_list_pkg::node_ptr_t meta_waddr;
	pq_list_pkg::node_ptr_t meta_raddr;
	pq_list_pkg::node_ptr_t rptr_waddr;
	pq_list_pkg::node_ptr_t rptr_raddr;
	pq_list_pkg::node_ptr_t rptr_wdata;
	pq_list_pkg::node_ptr_t rptr_rdata;
	pq_list_pkg::node_ptr_t lptr_waddr;
	pq_list_pkg::node_ptr_t lptr_raddr;
	pq_list_pkg::node_ptr_t lptr_wdata;
	pq_list_pkg::node_ptr_t lptr_rdata;

	// Free node FIFO
	logic alloc;
	logic release_req;
	logic free_empty;
	logic free_ready;
	pq_list_pkg::node_ptr_t free_ptr;
	pq_list_pkg::node_ptr_t release_ptr;

	rank_cache #(
		.CACHE_DEPTH(CACHE_DEPTH)
	) rank_cache_i (
		.clk,
		.rst,
		.insert(cache_insert),
		.rank_in(cache_rank),
		.meta_in(cache_meta),
		.evict(cache_evict),
		.remove(cache_remove),
		.rank_out,
		.meta_out,
		.valid_out,
		.max_rank(cache_max_rank),
		.max_meta(cache_max_meta),
		.count(cache_count),
		.empty(cache_empty),
		.full(cache_full)
	);

	spill_ctrl #(
		.CACHE_DEPTH(CACHE_DEPTH)
	) spill_ctrl_i (.*);

	list_engine list_engine_i (.*);

	node_store node_store_i (.*);

	free_list free_list_i (
		.*,
		.ready(free_ready)
	);

endmodule

`default_nettype wire

// File: rtl/spill_ctrl.sv
`default_nettype none

module spill_ctrl #(
	parameter int CACHE_DEPTH = 4,
	localparam int CNT_W = $clog2(CACHE_DEPTH + 1),
	localparam int NUM_W = $clog2(CACHE_DEPTH + pq_list_pkg::LIST_CAPACITY + 1)
) (
	input wire clk,
	input wire rst,
	input wire insert,
	input wire remove,
	input wire pq_entry_pkg::rank_t rank_in,
	input wire pq_entry_pkg::meta_t meta_in,
	input wire free_ready,
	input wire free_empty,
	output logic cache_insert,
	output pq_entry_pkg::rank_t cache_rank,
	output pq_entry_pkg::meta_t cache_meta,
	output logic cache_evict,
	output logic cache_remove,
	input wire pq_entry_pkg::rank_t cache_max_rank,
	input wire pq_entry_pkg::meta_t cache_max_meta,
	input wire [CNT_W-1:0] cache_count,
	input wire cache_empty,
	input wire cache_full,
	output logic ins_req,
	output pq_entry_pkg::rank_t ins_rank,
	output pq_entry_pkg::meta_t ins_meta,
	output logic pop_req,
	input wire pq_entry_pkg::rank_t pop_rank,
	input wire pq_entry_pkg::meta_t pop_meta,
	input wire pop_valid,
	input wire engine_idle,
	input wire pq_list_pkg::list_count_t list_count,
	output logic busy,
	output logic full,
	output logic [NUM_W-1:0] num_entries
);

	logic refill_due;
	logic refill_wait;
	logic accept_insert;
	logic spill;

	// Smallest list node belongs in the cache as soon as there is room
	assign refill_due = !cache_full && (list_count != '0);
	assign busy = !free_ready || !engine_idle || refill_wait || refill_due;
	assign full = free_empty;
	assign num_entries = NUM_W'(cache_count) + NUM_W'(list_count);

	// Remove wins, an insert in the same cycle is dropped
	assign cache_remove = remove && !busy && !cache_empty;
	assign accept_insert = insert && !remove && !busy && !full;
	assign spill = cache_full && (rank_in < cache_max_rank);

	assign cache_insert = (accept_insert && (!cache_full || spill)) || pop_valid;
	assign cache_evict = accept_insert && spill;
	assign cache_rank = pop_valid ? pop_rank : rank_in;
	assign cache_meta = pop_valid ? pop_meta : meta_in;

	// Full cache hands either its old max or the new entry to the list
	assign ins_req = accept_insert && cache_full;
	assign ins_rank = spill ? cache_max_rank : rank_in;
	assign ins_meta = spill ? cache_max_meta : meta_in;
	assign pop_req = refill_due && engine_idle && !refill_wait;

	always_ff @(posedge clk)
	begin
		if (rst)
			refill_wait <= 1'b0;
		else if (pop_req)
			refill_wait <= 1'b1;
		else if (pop_valid)
			refill_wait <= 1'b0;
	end

endmodule

`default_nettype wire

// File: rtl/list_engine.sv
`default_nettype none

module list_engine (
	input wire clk,
	input wire rst,
	input wire ins_req,
	input wire pq_entry_pkg::rank_t ins_rank,
	input wire pq_entry_pkg::meta_t ins_meta,
	input wire pop_req,
	output pq_entry_pkg::rank_t pop_rank,
	output pq_entry_pkg::meta_t pop_meta,
	output logic pop_valid,
	output logic engine_idle,
	output pq_list_pkg::list_count_t list_count,
	input wire free_ready,
	output logic rank_wr,
	output pq_list_pkg::node_ptr_t rank_waddr,
	output pq_entry_pkg::rank_t rank_wdata,
	output pq_list_pkg::node_ptr_t rank_raddr,
	input wire pq_entry_pkg::rank_t rank_rdata,
	output logic meta_wr,
	output pq_list_pkg::node_ptr_t meta_waddr,
	output pq_entry_pkg::meta_t meta_wdata,
	output pq_list_pkg::node_ptr_t meta_raddr,
	input wire pq_entry_pkg::meta_t meta_rdata,
	output logic rptr_wr,
	output pq_list_pkg::node_ptr_t rptr_waddr,
	output pq_list_pkg::node_ptr_t rptr_wdata,
	output pq_list_pkg::node_ptr_t rptr_raddr,
	input wire pq_list_pkg::node_ptr_t rptr_rdata,
	output logic lptr_wr,
	output pq_list_pkg::node_ptr_t lptr_waddr,
	output pq_list_pkg::node_ptr_t lptr_wdata,
	output pq_list_pkg::node_ptr_t lptr_raddr,
	input wire pq_list_pkg::node_ptr_t lptr_rdata,
	output logic alloc,
	input wire pq_list_pkg::node_ptr_t free_ptr,
	output logic release_req,
	output pq_list_pkg::node_ptr_t release_ptr
);

	localparam logic [3:0] S_INIT_WAIT = 4'd0;
	localparam logic [3:0] S_INIT_HEAD = 4'd1;
	localparam logic [3:0] S_INIT_TAIL = 4'd2;
	localparam logic [3:0] S_IDLE = 4'd3;
	localparam logic [3:0] S_WALK_WAIT = 4'd4;
	localparam logic [3:0] S_WALK_CHK = 4'd5;
	localparam logic [3:0] S_LINK_NEW = 4'd6;
	localparam logic [3:0] S_LINK_NEAR = 4'd7;
	localparam logic [3:0] S_POP_WAIT = 4'd8;
	localparam logic [3:0] S_POP_LINK = 4'd9;

	logic [3:0] state;
	logic found;
	pq_list_pkg::node_ptr_t rd_addr;
	pq_list_pkg::node_ptr_t cur;
	pq_list_pkg::node_ptr_t prev;
	pq_list_pkg::node_ptr_t low_node;
	pq_entry_pkg::rank_t key_rank;
	pq_entry_pkg::meta_t key_meta;

	// All fields of a node are read together
	assign rank_raddr = rd_addr;
	assign meta_raddr = rd_addr;
	assign rptr_raddr = rd_addr;
	assign lptr_raddr = rd_addr;

	assign engine_idle = (state == S_IDLE);
	assign release_ptr = low_node;
	// Stop at the first node ranked below the key; the tail catches a key of zero
	assign found = (rank_rdata < key_rank) || (cur == pq_list_pkg::TAIL_NODE);

	always_comb
	begin
		// By default the new node sits at the free head between prev and cur
		rank_wr = 1'b0;
		rank_waddr = free_ptr;
		rank_wdata = key_rank;
		meta_wr = 1'b0;
		meta_waddr = free_ptr;
		meta_wdata = key_meta;
		rptr_wr = 1'b0;
		rptr_waddr = free_ptr;
		rptr_wdata = cur;
		lptr_wr = 1'b0;
		lptr_waddr = free_ptr;
		lptr_wdata = prev;
		alloc = 1'b0;
		release_req = 1'b0;
		case (state)
			S_INIT_HEAD:
			begin
				rank_wr = 1'b1;
				rank_waddr = pq_list_pkg::HEAD_NODE;
				rank_wdata = pq_entry_pkg::RANK_MAX;
				rptr_wr = 1'b1;
				rptr_waddr = pq_list_pkg::HEAD_NODE;
				rptr_wdata = pq_list_pkg::TAIL_NODE;
				lptr_wr = 1'b1;
				lptr_waddr = pq_list_pkg::HEAD_NODE;
				lptr_wdata = pq_list_pkg::NULL_PTR;
			end
			S_INIT_TAIL:
			begin
				rank_wr = 1'b1;
				rank_waddr = pq_list_pkg::TAIL_NODE;
				rank_wdata = pq_entry_pkg::RANK_MIN;
				rptr_wr = 1'b1;
				rptr_waddr = pq_list_pkg::TAIL_NODE;
				rptr_wdata = pq_list_pkg::NULL_PTR;
				lptr_wr = 1'b1;
				lptr_waddr = pq_list_pkg::TAIL_NODE;
				lptr_wdata = pq_list_pkg::HEAD_NODE;
			end
			S_LINK_NEW:
			begin
				rank_wr = 1'b1;
				meta_wr = 1'b1;
				rptr_wr = 1'b1;
				lptr_wr = 1'b1;
			end
			S_LINK_NEAR:
			begin
				rptr_wr = 1'b1;
				rptr_waddr = prev;
				rptr_wdata = free_ptr;
				lptr_wr = 1'b1;
				lptr_waddr = cur;
				lptr_wdata = free_ptr;
				alloc = 1'b1;
			end
			S_POP_LINK:
			begin
				// Left neighbour of the popped node becomes the last before the tail
				rptr_wr = 1'b1;
				rptr_waddr = lptr_rdata;
				rptr_wdata = pq_list_pkg::TAIL_NODE;
				lptr_wr = 1'b1;
				lptr_waddr = pq_list_pkg::TAIL_NODE;
				lptr_wdata = lptr_rdata;
				release_req = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= S_INIT_WAIT;
			low_node <= pq_list_pkg::HEAD_NODE;
			list_count <= '0;
			pop_valid <= 1'b0;
		end
		else
		begin
			pop_valid <= 1'b0;
			case (state)
				S_INIT_WAIT:
					if (free_ready)
						state <= S_INIT_HEAD;
				S_INIT_HEAD:
					state <= S_INIT_TAIL;
				S_INIT_TAIL:
					state <= S_IDLE;
				S_IDLE:
					if (pop_req)
					begin
						rd_addr <= low_node;
						state <= S_POP_WAIT;
					end
					else if (ins_req)
					begin
						rd_addr <= pq_list_pkg::HEAD_NODE;
						cur <= pq_list_pkg::HEAD_NODE;
						key_rank <= ins_rank;
						key_meta <= ins_meta;
						state <= S_WALK_WAIT;
					end
				S_WALK_WAIT:
					state <= S_WALK_CHK;
				S_WALK_CHK:
					if (found)
						state <= S_LINK_NEW;
					else
					begin
						prev <= cur;
						cur <= rptr_rdata;
						rd_addr <= rptr_rdata;
						state <= S_WALK_WAIT;
					end
				S_LINK_NEW:
					state <= S_LINK_NEAR;
				S_LINK_NEAR:
				begin
					if (cur == pq_list_pkg::TAIL_NODE)
						low_node <= free_ptr;
					list_count <= list_count + 1'b1;
					state <= S_IDLE;
				end
				S_POP_WAIT:
					state <= S_POP_LINK;
				S_POP_LINK:
				begin
					pop_rank <= rank_rdata;
					pop_meta <= meta_rdata;
					pop_valid <= 1'b1;
					low_node <= lptr_rdata;
					list_count <= list_count - 1'b1;
					state <= S_IDLE;
				end
				default:
					state <= S_INIT_WAIT;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/node_store.sv
`default_nettype none

module node_store (
	input wire clk,
	input wire rank_wr,
	input wire pq_list_pkg::node_ptr_t rank_waddr,
	input wire pq_entry_pkg::rank_t rank_wdata,
	input wire pq_list_pkg::node_ptr_t rank_raddr,
	output pq_entry_pkg::rank_t rank_rdata,
	input wire meta_wr,
	input wire pq_list_pkg::node_ptr_t meta_waddr,
	input wire pq_entry_pkg::meta_t meta_wdata,
	input wire pq_list_pkg::node_ptr_t meta_raddr,
	output pq_entry_pkg::meta_t meta_rdata,
	input wire rptr_wr,
	input wire pq_list_pkg::node_ptr_t rptr_waddr,
	input wire pq_list_pkg::node_ptr_t rptr_wdata,
	input wire pq_list_pkg::node_ptr_t rptr_raddr,
	output pq_list_pkg::node_ptr_t rptr_rdata,
	input wire lptr_wr,
	input wire pq_list_pkg::node_ptr_t lptr_waddr,
	input wire pq_list_pkg::node_ptr_t lptr_wdata,
	input wire pq_list_pkg::node_ptr_t lptr_raddr,
	output pq_list_pkg::node_ptr_t lptr_rdata
);

	pq_entry_pkg::rank_t rank_mem [pq_list_pkg::NODE_COUNT];
	pq_entry_pkg::meta_t meta_mem [pq_list_pkg::NODE_COUNT];
	pq_list_pkg::node_ptr_t rptr_mem [pq_list_pkg::NODE_COUNT];
	pq_list_pkg::node_ptr_t lptr_mem [pq_list_pkg::NODE_COUNT];

	// One simple dual-port RAM per field with read data one cycle after the address
	always_ff @(posedge clk)
	begin
		if (rank_wr)
			rank_mem[rank_waddr] <= rank_wdata;
		rank_rdata <= rank_mem[rank_raddr];
	end

	always_ff @(posedge clk)
	begin
		if (meta_wr)
			meta_mem[meta_waddr] <= meta_wdata;
		meta_rdata <= meta_mem[meta_raddr];
	end

	always_ff @(posedge clk)
	begin
		if (rptr_wr)
			rptr_mem[rptr_waddr] <= rptr_wdata;
		rptr_rdata <= rptr_mem[rptr_raddr];
	end

	always_ff @(posedge clk)
	begin
		if (lptr_wr)
			lptr_mem[lptr_waddr] <= lptr_wdata;
		lptr_rdata <= lptr_mem[lptr_raddr];
	end

endmodule

`default_nettype wire

// File: rtl/free_list.sv
`default_nettype none

module free_list (
	input wire clk,
	input wire rst,
	input wire alloc,
	output pq_list_pkg::node_ptr_t free_ptr,
	input wire release_req,
	input wire pq_list_pkg::node_ptr_t release_ptr,
	output logic free_empty,
	output logic ready
);

	pq_list_pkg::node_ptr_t mem [pq_list_pkg::NODE_COUNT];
	pq_list_pkg::node_ptr_t rd_ptr;
	pq_list_pkg::node_ptr_t wr_ptr;
	pq_list_pkg::node_ptr_t init_ptr;
	pq_list_pkg::list_count_t occupancy;
	logic filling;
	logic push;

	// Self-fill owns the write side until every spare node is queued
	assign push = filling || release_req;
	assign free_ptr = mem[rd_ptr];
	assign ready = !filling;
	assign free_empty = ready && (occupancy == '0);

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= filling ? init_ptr : release_ptr;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			occupancy <= '0;
			init_ptr <= pq_list_pkg::FIRST_FREE_NODE;
			filling <= 1'b1;
		end
		else
		begin
			if (filling)
			begin
				init_ptr <= init_ptr + 1'b1;
				if (init_ptr == pq_list_pkg::node_ptr_t'(pq_list_pkg::NODE_COUNT - 1))
					filling <= 1'b0;
			end
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (alloc)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !alloc)
				occupancy <= occupancy + 1'b1;
			else if (alloc && !push)
				occupancy <= occupancy - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/rank_cache.sv
`default_nettype none

module rank_cache #(
	parameter int CACHE_DEPTH = 4,
	localparam int CNT_W = $clog2(CACHE_DEPTH + 1),
	localparam int IDX_W = $clog2(CACHE_DEPTH)
) (
	input wire clk,
	input wire rst,
	input wire insert,
	input wire pq_entry_pkg::rank_t rank_in,
	input wire pq_entry_pkg::meta_t meta_in,
	input wire evict,
	input wire remove,
	output pq_entry_pkg::rank_t rank_out,
	output pq_entry_pkg::meta_t meta_out,
	output logic valid_out,
	output pq_entry_pkg::rank_t max_rank,
	output pq_entry_pkg::meta_t max_meta,
	output logic [CNT_W-1:0] count,
	output logic empty,
	output logic full
);

	pq_entry_pkg::rank_t rank_q [CACHE_DEPTH];
	pq_entry_pkg::meta_t meta_q [CACHE_DEPTH];
	logic [CACHE_DEPTH-1:0] below;
	logic [IDX_W-1:0] max_idx;

	// Valid slots ranked under the new entry form a thermometer since slots stay sorted
	always_comb
	begin
		for (int i = 0; i < CACHE_DEPTH; i++)
		begin
			below[i] = (i < count) && (rank_q[i] < rank_in);
		end
	end

	assign empty = (count == '0);
	assign full = (count == CNT_W'(CACHE_DEPTH));
	assign max_idx = empty ? '0 : IDX_W'(count - 1'b1);
	assign max_rank = rank_q[max_idx];
	assign max_meta = meta_q[max_idx];

	always_ff @(posedge clk)
	begin
		if (remove)
		begin
			rank_out <= rank_q[0];
			meta_out <= meta_q[0];
			for (int i = 0; i < CACHE_DEPTH - 1; i++)
			begin
				rank_q[i] <= rank_q[i + 1];
				meta_q[i] <= meta_q[i + 1];
			end
		end
		else if (insert)
		begin
			if (!below[0])
			begin
				rank_q[0] <= rank_in;
				meta_q[0] <= meta_in;
			end
			// Entries above the insert point move up one slot, the last one falls off
			for (int i = 1; i < CACHE_DEPTH; i++)
			begin
				if (below[i - 1] && !below[i])
				begin
					rank_q[i] <= rank_in;
					meta_q[i] <= meta_in;
				end
				else if (!below[i - 1])
				begin
					rank_q[i] <= rank_q[i - 1];
					meta_q[i] <= meta_q[i - 1];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count <= '0;
			valid_out <= 1'b0;
		end
		else
		begin
			valid_out <= remove;
			if (remove)
				count <= count - 1'b1;
			// Evict keeps the count, the new entry takes the dropped slot
			else if (insert && !evict)
				count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/pq_list_pkg.sv
`default_nettype none

package pq_list_pkg;

	localparam int NODE_ADDR_WIDTH = 5;
	localparam int NODE_COUNT = 2 ** NODE_ADDR_WIDTH;

	typedef logic [NODE_ADDR_WIDTH-1:0] node_ptr_t;
	typedef logic [NODE_ADDR_WIDTH:0] list_count_t;

	// Sentinels sit in the two lowest nodes, the rest go to the free list
	localparam node_ptr_t HEAD_NODE = 0;
	localparam node_ptr_t TAIL_NODE = 1;
	localparam node_ptr_t FIRST_FREE_NODE = 2;
	localparam node_ptr_t NULL_PTR = '1;

	localparam int LIST_CAPACITY = NODE_COUNT - 2;

endpackage

`default_nettype wire

// File: rtl/pq_entry_pkg.sv
`default_nettype none

package pq_entry_pkg;

	localparam int RANK_WIDTH = 10;
	localparam int META_WIDTH = 10;

	typedef logic [RANK_WIDTH-1:0] rank_t;
	typedef logic [META_WIDTH-1:0] meta_t;

	// Head sentinel holds the top rank, tail sentinel the bottom one
	localparam rank_t RANK_MAX = '1;
	localparam rank_t RANK_MIN = '0;

endpackage

`default_nettype wire
